// ==== tb/int_cases.txt ====
# name op a b expected, all numbers hex
# W write flags, Q irq lines, A atomic, F/S read, I hold in_service a cycles, V service (a = gaps)
reset_flags   F 0        0 00000000
ena_all       W 000101f0 0 0
ena_all_rd    F 0        0 000001f0
atomic_on     A 1        0 0
ena_0_2       W 00000050 0 0
ena_0_2_rd    F 0        0 00000050
irq1_off_ena  Q 2        0 0
irq1_no_lat   S 0        0 00000000
irq2_on       Q 4        0 0
irq2_lat      S 0        0 00000100
irq2_off      Q 0        0 0
irq2_held     S 0        0 00000100
irq2_clear    W 00000850 0 0
irq2_cleared  S 0        0 00000000
irq0_2_on     Q 5        0 0
irq0_2_lat    S 0        0 00000140
atomic_hold   I 8        0 0
atomic_off    A 0        0 0
irq0_2_off    Q 0        0 0
svc_irq2      V 0        0 00f03020
mask_set_rd   F 0        0 00000058
mask_hold     I 10       0 0
mask_lat_rd   S 0        0 00000140
unmask_clr2   W 00000850 0 0
svc_irq0_gap  V 1        0 00f03000
ena_0_4       W 00000310 0 0
idle_check    I 4        0 0
irq0_4_on     Q 11       0 0
svc_irq4_gap  V 1        0 00f03040
irq0_4_off    Q 0        0 0
mask_ena_rd   F 0        0 00000118
lat_0_4_rd    S 0        0 00000440

// ==== tb.f ====
src/risc_int_pkg.sv
src/flag_port.sv
src/int_latch.sv
src/int_sequencer.sv
src/risc_int_top.sv
tb/risc_int_tb.sv

// ==== Makefile ====
# Verilator build and run for the interrupt unit testbench

VERILATOR ?= verilator
TOP       ?= risc_int_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= SIMULATION PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// ==== tb/risc_int_tb.sv ====
//****************************************
// Self-checking testbench for the interrupt unit,
// driven from the cases file
//****************************************
module risc_int_tb
	import risc_int_pkg::*;
();

	localparam int NUM_IRQ = 5;
	// Cycles allowed for service to start once it should
	localparam int START_LIMIT = 20;

	logic               sys_clk;
	logic               resetl;
	logic [31:0]        din;
	logic               flag_wr;
	logic               flag_rd;
	logic               stat_rd;
	logic [NUM_IRQ-1:0] irq;
	logic               atomic;
	logic               rom_fetch;
	logic [31:0]        dout;
	logic               dout_oe;
	logic               imask;
	logic               in_service;
	logic [15:0]        ins;

	// Case table, one entry per data line
	string       case_name[$];
	string       case_op[$];
	logic [31:0] case_a[$];
	logic [31:0] case_exp[$];
	int          n_cases;
	int          n_fail;
	int          case_errs;
	bit          loaded;
	bit          file_ok;
	bit          load_err;

	risc_int_top #(
		.NUM_IRQ (NUM_IRQ)
	) risc_int_top_inst (
		.sys_clk    (sys_clk),
		.resetl     (resetl),
		.din        (din),
		.flag_wr    (flag_wr),
		.flag_rd    (flag_rd),
		.stat_rd    (stat_rd),
		.irq        (irq),
		.atomic     (atomic),
		.rom_fetch  (rom_fetch),
		.dout       (dout),
		.dout_oe    (dout_oe),
		.imask      (imask),
		.in_service (in_service),
		.ins        (ins)
	);

	initial begin
		sys_clk = 1'b0;
		forever #5 sys_clk = ~sys_clk;
	end

	// Word k of the injected sequence for a given vector
	function automatic logic [15:0] service_word(input int k, input logic [31:0] vec);
		logic [15:0] w;
		case (k)
			0:       w = SEQ_SUBQ;
			1:       w = SEQ_MOVE_PC;
			2:       w = SEQ_STORE;
			3:       w = SEQ_MOVEI;
			4:       w = vec[15:0];
			5:       w = vec[31:16];
			6:       w = SEQ_JUMP;
			default: w = SEQ_NOP;
		endcase
		return w;
	endfunction

	task automatic compare_word(input string nm, input logic [31:0] exp, input logic [31:0] act);
		assert (act == exp) else begin
			$display("ERROR %s: expected %h, actual %h", nm, exp, act);
			case_errs++;
		end
	endtask

	// Comment lines start with '#', others hold five fields
	task automatic load_cases(output bit ok);
		int    fd;
		int    cnt;
		string line;
		string nm;
		string op;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] exp;
		ok = 1'b0;
		fd = $fopen("tb/int_cases.txt", "r");
		if (fd != 0) begin
			while ($fgets(line, fd) != 0) begin
				if (line.len() > 1 && line.getc(0) != "#") begin
					cnt = $sscanf(line, "%s %s %h %h %h", nm, op, a, b, exp);
					if (cnt == 5) begin
						case_name.push_back(nm);
						case_op.push_back(op);
						case_a.push_back(a);
						case_exp.push_back(exp);
					end
				end
			end
			$fclose(fd);
			ok = 1'b1;
		end
		n_cases = case_name.size();
	endtask

	// Single-cycle flag write
	task automatic write_flags(input logic [31:0] w);
		din     = w;
		flag_wr = 1'b1;
		@(negedge sys_clk);
		flag_wr = 1'b0;
		din     = '0;
	endtask

	// Flags or status read, then the bus must go quiet
	task automatic read_word(input string nm, input bit stat, input logic [31:0] exp);
		flag_rd = ~stat;
		stat_rd = stat;
		@(negedge sys_clk);
		compare_word(nm, exp, dout);
		compare_word(nm, 32'd1, {31'd0, dout_oe});
		flag_rd = 1'b0;
		stat_rd = 1'b0;
		@(negedge sys_clk);
		compare_word(nm, 32'd0, dout);
		compare_word(nm, 32'd0, {31'd0, dout_oe});
	endtask

	// in_service must sit at one level for a number of cycles
	task automatic hold_check(input string nm, input int cycles, input logic level);
		repeat (cycles) begin
			@(negedge sys_clk);
			compare_word(nm, {31'd0, level}, {31'd0, in_service});
		end
	endtask

	// Wait for service, then pull eight words, with random gaps if asked
	task automatic run_service(input string nm, input bit gaps, input logic [31:0] vec);
		int waited;
		int gap;
		waited = 0;
		while (!in_service && waited < START_LIMIT) begin
			@(negedge sys_clk);
			waited++;
		end
		assert (in_service) else begin
			$display("Service did not start within %0d cycles in %s", START_LIMIT, nm);
			case_errs++;
		end
		if (in_service) begin
			for (int k = 0; k < 8; k++) begin
				if (gaps) begin
					gap = $urandom_range(3, 0);
					repeat (gap) @(negedge sys_clk);
				end
				compare_word(nm, {16'd0, service_word(k, vec)}, {16'd0, ins});
				rom_fetch = 1'b1;
				@(negedge sys_clk);
				rom_fetch = 1'b0;
			end
			// Sequence over, mask left set
			compare_word(nm, 32'd0, {31'd0, in_service});
			compare_word(nm, 32'd1, {31'd0, imask});
		end
	endtask

	initial begin
		void'($urandom(32'h4b1a_ec04));
		resetl    = 1'b0;
		din       = '0;
		flag_wr   = 1'b0;
		flag_rd   = 1'b0;
		stat_rd   = 1'b0;
		irq       = '0;
		atomic    = 1'b0;
		rom_fetch = 1'b0;
		n_fail    = 0;
		loaded    = 1'b0;
		load_err  = 1'b0;
		load_cases(file_ok);
		if (!file_ok || n_cases == 0) begin
			$display("No cases could be read from tb/int_cases.txt");
			load_err = 1'b1;
		end
		loaded = 1'b1;
		repeat (5) @(negedge sys_clk);
		resetl = 1'b1;
		for (int i = 0; i < n_cases; i++) begin
			case_errs = 0;
			case (case_op[i])
				"W": write_flags(case_a[i]);
				"Q": begin
					irq = case_a[i][NUM_IRQ-1:0];
					@(negedge sys_clk);
				end
				"A": begin
					atomic = case_a[i][0];
					@(negedge sys_clk);
				end
				"F": read_word(case_name[i], 1'b0, case_exp[i]);
				"S": read_word(case_name[i], 1'b1, case_exp[i]);
				"I": hold_check(case_name[i], int'(case_a[i]), case_exp[i][0]);
				"V": run_service(case_name[i], case_a[i][0], case_exp[i]);
				default: begin
					$display("Unknown operation %s in %s", case_op[i], case_name[i]);
					case_errs++;
				end
			endcase
			if (case_errs == 0) begin
				$display("PASS %s", case_name[i]);
			end else begin
				$display("FAIL %s", case_name[i]);
				n_fail++;
			end
		end
		$display("Cases run %0d, passed %0d, failed %0d", n_cases, n_cases - n_fail, n_fail);
		if (n_fail == 0 && !load_err) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

	// Watchdog, 200 cycles per case on top of the reset cycles
	initial begin
		wait (loaded);
		#((n_cases * 200 + 5) * 10);
		$display("Timeout, the run did not finish in %0d cycles", n_cases * 200 + 5);
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// ==== src/risc_int_top.sv ====
//****************************************
// Interrupt unit top level
//****************************************
module risc_int_top
	import risc_int_pkg::*;
#(
	parameter int          NUM_IRQ  = 5,
	parameter logic [31:0] VEC_BASE = 32'h00F0_3000
) (
	input  logic               sys_clk,
	input  logic               resetl,
	input  logic [31:0]        din,
	input  logic               flag_wr,
	input  logic               flag_rd,
	input  logic               stat_rd,
	input  logic [NUM_IRQ-1:0] irq,
	input  logic               atomic,
	input  logic               rom_fetch,
	output logic [31:0]        dout,
	output logic               dout_oe,
	output logic               imask,
	output logic               in_service,
	output logic [15:0]        ins
);

	flag_cmd_t          cmd;
	int_req_t           req;
	logic [NUM_IRQ-1:0] ena;
	logic [NUM_IRQ-1:0] lat;

	// Core data port, write decode and read mux
	flag_port #(
		.NUM_IRQ (NUM_IRQ)
	) flag_port_inst (
		.sys_clk (sys_clk),
		.resetl  (resetl),
		.din     (din),
		.flag_wr (flag_wr),
		.flag_rd (flag_rd),
		.stat_rd (stat_rd),
		.ena     (ena),
		.lat     (lat),
		.imask   (imask),
		.cmd     (cmd),
		.dout    (dout),
		.dout_oe (dout_oe)
	);

	// Peripheral request capture
	int_latch #(
		.NUM_IRQ (NUM_IRQ)
	) int_latch_inst (
		.sys_clk (sys_clk),
		.resetl  (resetl),
		.irq     (irq),
		.cmd     (cmd),
		.ena     (ena),
		.lat     (lat),
		.req     (req)
	);

	// Service sequence toward the fetch unit
	int_sequencer #(
		.VEC_BASE (VEC_BASE)
	) int_sequencer_inst (
		.sys_clk    (sys_clk),
		.resetl     (resetl),
		.req        (req),
		.cmd        (cmd),
		.atomic     (atomic),
		.rom_fetch  (rom_fetch),
		.in_service (in_service),
		.imask      (imask),
		.ins        (ins)
	);

endmodule

// ==== src/int_sequencer.sv ====
//****************************************
// In-service FSM, mask, word counter and
// injected instruction generator
//****************************************
module int_sequencer
	import risc_int_pkg::*;
#(
	parameter logic [31:0] VEC_BASE = 32'h00F0_3000
) (
	input  logic        sys_clk,
	input  logic        resetl,
	input  int_req_t    req,
	input  flag_cmd_t   cmd,
	input  logic        atomic,
	input  logic        rom_fetch,
	output logic        in_service,
	output logic        imask,
	output logic [15:0] ins
);

	logic        start;
	logic        fetch;
	logic        last;
	logic [2:0]  count;
	logic [2:0]  cap_num;
	logic [31:0] vector;

	// Service may start only between sequences and outside atomic code
	assign start = req.pending & ~in_service & ~imask & ~atomic;

	// One injected word consumed
	assign fetch = rom_fetch & in_service;

	// Jump word has gone, the NOP is the final fetch
	assign last = fetch & (count == 3'd7);

	// In-service flag
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			in_service <= 1'b0;
		end else if (start) begin
			in_service <= 1'b1;
		end else if (last) begin
			in_service <= 1'b0;
		end
	end

	// Word counter wraps back to 0 after the eighth word
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			count <= '0;
		end else if (fetch) begin
			count <= count + 3'd1;
		end
	end

	// Mask is set by the sequence itself, cleared by software
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			imask <= 1'b0;
		end else if (fetch) begin
			imask <= 1'b1;
		end else if (cmd.imask_clr) begin
			imask <= 1'b0;
		end
	end

	// Number frozen for the whole sequence
	always_ff @(posedge sys_clk) begin
		if (start) begin
			cap_num <= req.num;
		end
	end

	// Sixteen bytes of handler space per request
	assign vector = VEC_BASE + {25'd0, cap_num, 4'd0};

	// Injected word select
	always_comb begin
		case (count)
			3'd0:    ins = SEQ_SUBQ;
			3'd1:    ins = SEQ_MOVE_PC;
			3'd2:    ins = SEQ_STORE;
			3'd3:    ins = SEQ_MOVEI;
			// movei takes its immediate low half first
			3'd4:    ins = vector[15:0];
			3'd5:    ins = vector[31:16];
			3'd6:    ins = SEQ_JUMP;
			default: ins = SEQ_NOP;
		endcase
	end

	// Counter is frozen outside service
	a_cnt_idle: assert property (@(posedge sys_clk) disable iff (!resetl)
		!in_service |=> $stable(count));

endmodule

// ==== src/int_latch.sv ====
//****************************************
// Enable register, request latch and
// priority encoder
//****************************************
module int_latch
	import risc_int_pkg::*;
#(
	parameter int NUM_IRQ = 5
) (
	input  logic               sys_clk,
	input  logic               resetl,
	input  logic [NUM_IRQ-1:0] irq,
	input  flag_cmd_t          cmd,
	output logic [NUM_IRQ-1:0] ena,
	output logic [NUM_IRQ-1:0] lat,
	output int_req_t           req
);

	logic [NUM_IRQ-1:0] live;
	logic [NUM_IRQ-1:0] lat_next;
	logic [2:0]         top_num;

	// Requests seen through their enables
	assign live = irq & ena;

	// Clear first, then a live request sets again
	assign lat_next = (lat & ~cmd.clr[NUM_IRQ-1:0]) | live;

	// Enables load on every flag write
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			ena <= '0;
		end else if (cmd.ena_wr) begin
			ena <= cmd.ena_val[NUM_IRQ-1:0];
		end
	end

	// Request latch
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			lat <= '0;
		end else begin
			lat <= lat_next;
		end
	end

	// Highest index wins, later iterations override
	always_comb begin
		top_num = '0;
		for (int i = 0; i < NUM_IRQ; i++) begin
			if (lat[i]) begin
				top_num = 3'(i);
			end
		end
	end

	always_comb begin
		req.pending = |lat;
		req.num     = top_num;
	end

	// Encoded number always names a real line
	a_num_range: assert property (@(posedge sys_clk) disable iff (!resetl)
		req.pending |-> (int'(req.num) < NUM_IRQ));

endmodule

// ==== src/flag_port.sv ====
//****************************************
// Flag write decoder and flags/status read mux
//****************************************
module flag_port
	import risc_int_pkg::*;
#(
	parameter int NUM_IRQ = 5
) (
	input  logic                sys_clk,
	input  logic                resetl,
	input  logic [31:0]         din,
	input  logic                flag_wr,
	input  logic                flag_rd,
	input  logic                stat_rd,
	input  logic [NUM_IRQ-1:0]  ena,
	input  logic [NUM_IRQ-1:0]  lat,
	input  logic                imask,
	output flag_cmd_t           cmd,
	output logic [31:0]         dout,
	output logic                dout_oe
);

	// Lines held in the low field of each group
	localparam int LO_N = MAX_IRQ - 1;
	// Only lines that exist may be written
	localparam logic [MAX_IRQ-1:0] IRQ_MASK = MAX_IRQ'((1 << NUM_IRQ) - 1);

	logic [MAX_IRQ-1:0] ena_in;
	logic [MAX_IRQ-1:0] clr_in;
	logic [MAX_IRQ-1:0] ena_x;
	logic [MAX_IRQ-1:0] lat_x;
	logic [31:0]        flags_word;
	logic [31:0]        stat_word;

	// Gather the split enable and clear fields
	assign ena_in = {din[FLAG_ENA_HI], din[FLAG_ENA_LO +: LO_N]};
	assign clr_in = {din[FLAG_CLR_HI], din[FLAG_CLR_LO +: LO_N]};

	// Write decode
	always_comb begin
		cmd.ena_wr    = flag_wr;
		cmd.ena_val   = ena_in & IRQ_MASK;
		// Clears and mask clear are strobes, only live during a write
		cmd.clr       = flag_wr ? (clr_in & IRQ_MASK) : '0;
		cmd.imask_clr = flag_wr & ~din[FLAG_IMASK];
	end

	// Widen the register views to the full field size
	always_comb begin
		ena_x = '0;
		lat_x = '0;
		ena_x[NUM_IRQ-1:0] = ena;
		lat_x[NUM_IRQ-1:0] = lat;
	end

	// Flags read, mask and enables
	always_comb begin
		flags_word = '0;
		flags_word[FLAG_IMASK] = imask;
		flags_word[FLAG_ENA_LO +: LO_N] = ena_x[LO_N-1:0];
		flags_word[FLAG_ENA_HI] = ena_x[LO_N];
	end

	// Status read, request latches
	always_comb begin
		stat_word = '0;
		stat_word[STAT_LAT_LO +: LO_N] = lat_x[LO_N-1:0];
		stat_word[STAT_LAT_HI] = lat_x[LO_N];
	end

	// Both sources share the core data bus
	assign dout    = (flag_rd ? flags_word : '0) | (stat_rd ? stat_word : '0);
	assign dout_oe = flag_rd | stat_rd;

	// Core never reads and writes the flags in one cycle
	a_no_rd_on_wr: assert property (@(posedge sys_clk) disable iff (!resetl)
		flag_wr |-> !(flag_rd || stat_rd));

endmodule

// ==== src/risc_int_pkg.sv ====
//****************************************
// Flags word bit positions, command and request
// structs, service-sequence opcodes
//****************************************
package risc_int_pkg;

	// Upper bound on peripheral request lines
	localparam int MAX_IRQ = 6;

	// Flags word, write and read layout
	localparam int FLAG_IMASK  = 3;
	// Low enables sit at bits 4 to 8
	localparam int FLAG_ENA_LO = 4;
	// Low latch clears sit at bits 9 to 13
	localparam int FLAG_CLR_LO = 9;
	// Request 5 has its enable and clear up here
	localparam int FLAG_ENA_HI = 16;
	localparam int FLAG_CLR_HI = 17;

	// Status word, latch bits 0 to 4 then latch bit 5
	localparam int STAT_LAT_LO = 6;
	localparam int STAT_LAT_HI = 16;

	// One decoded flag write
	typedef struct packed {
		logic               ena_wr;
		logic [MAX_IRQ-1:0] ena_val;
		logic [MAX_IRQ-1:0] clr;
		logic               imask_clr;
	} flag_cmd_t;

	// Highest pending request
	typedef struct packed {
		logic       pending;
		logic [2:0] num;
	} int_req_t;

	// Injected service words
	localparam logic [15:0] SEQ_SUBQ    = 16'h1C9F; // subq 4,r31
	localparam logic [15:0] SEQ_MOVE_PC = 16'hCC1E; // move pc,r30
	localparam logic [15:0] SEQ_STORE   = 16'hBFFE; // store r30,(r31)
	localparam logic [15:0] SEQ_MOVEI   = 16'h981E; // movei vector,r30
	localparam logic [15:0] SEQ_JUMP    = 16'hD3C0; // jump (r30)
	localparam logic [15:0] SEQ_NOP     = 16'hE400;

endpackage
